/* Bender.yml */
package:
  name: decode_stage

sources:
  # Shared package first, the decoders read its types
  - files:
      - common/decodePkg.sv
      - hw/decode/decodeFpu0.sv
      - hw/decode/decodeMemory.sv
      - hw/decode/decodeBranch.sv
      - hw/decode/decodeRegisters.sv
      - hw/decode/decodeStage.sv

  - target: test
    files:
      - test/decodeTb.sv

/* common/decodePkg.sv */
/*
 * Decode package for the out-of-order core front end.
 * Holds the instruction formats, the opcode and function encodings,
 * the unit and access size codes and the decode bundle.
 */

`default_nettype none

package decodePkg;

	// ==================================================================
	// Field widths
	// ==================================================================

	// Every instruction is one 32-bit word
	localparam int INSTR_BITS = 32;
	localparam int OPCODE_BITS = 7;
	localparam int REG_BITS = 6;

	// Raw displacement widths of the memory and branch formats
	localparam int MEM_DISP_BITS = 13;
	localparam int BR_DISP_BITS = 10;

	// Displacements leave the decoder at full data width
	localparam int DISP_BITS = 32;

	// A call saves its return address in this register
	localparam logic [REG_BITS-1:0] LINK_REG = 6'd1;

	// ==================================================================
	// Encodings
	// ==================================================================

	// Primary opcodes, any code not listed here is illegal
	typedef enum logic [OPCODE_BITS-1:0] {
		OP_NOP   = 7'h00,
		OP_ALU   = 7'h02,
		OP_ADDI  = 7'h04,
		OP_CAP   = 7'h07,
		OP_FLT3H = 7'h0C,
		OP_FLT3S = 7'h0D,
		OP_FLT3D = 7'h0E,
		OP_FLT3Q = 7'h0F,
		OP_JSR   = 7'h20,
		OP_BCC   = 7'h28,
		OP_LDB   = 7'h40,
		OP_LDW   = 7'h41,
		OP_LDT   = 7'h42,
		OP_LDO   = 7'h43,
		OP_STB   = 7'h48,
		OP_STW   = 7'h49,
		OP_STT   = 7'h4A,
		OP_STO   = 7'h4B
	} opcode_t;

	// Function field of the three operand float format
	typedef enum logic [3:0] {
		FN_FADD = 4'h0,
		FN_FMUL = 4'h1,
		FN_FDIV = 4'h2,
		FN_FLT1 = 4'hF
	} flt3Func_t;

	// Single operand float functions, selected when the outer func is FN_FLT1
	typedef enum logic [5:0] {
		FN_FABS  = 6'h01,
		FN_FNEG  = 6'h02,
		FN_FRES  = 6'h08,
		FN_FSQRT = 6'h09,
		FN_FSIN  = 6'h10,
		FN_FCOS  = 6'h11
	} flt1Func_t;

	// Access size, given by the last letter of the load or store mnemonic
	typedef enum logic [1:0] {
		SIZE_BYTE  = 2'd0,
		SIZE_WYDE  = 2'd1,
		SIZE_TETRA = 2'd2,
		SIZE_OCTA  = 2'd3
	} memSize_t;

	// Execution unit that the instruction issues to
	typedef enum logic [2:0] {
		UNIT_NONE   = 3'd0,
		UNIT_ALU    = 3'd1,
		UNIT_FPU    = 3'd2,
		UNIT_FPU0   = 3'd3,
		UNIT_MEM    = 3'd4,
		UNIT_BRANCH = 3'd5
	} unit_t;

	// ==================================================================
	// Instruction formats
	// ==================================================================

	// All formats keep the opcode in the low seven bits
	typedef union packed {
		logic [INSTR_BITS-1:0] raw;
		struct packed {
			logic [6:0] func;
			logic [REG_BITS-1:0] rs2;
			logic [REG_BITS-1:0] rs1;
			logic [REG_BITS-1:0] rd;
			logic [OPCODE_BITS-1:0] opcode;
		} r3;
		struct packed {
			logic [3:0] func;
			logic [2:0] rm;
			logic [REG_BITS-1:0] rs2;
			logic [REG_BITS-1:0] rs1;
			logic [REG_BITS-1:0] rd;
			logic [OPCODE_BITS-1:0] opcode;
		} f3;
		// The single operand function takes the place of rs2
		struct packed {
			logic [3:0] f3Func;
			logic [2:0] rm;
			logic [5:0] func;
			logic [REG_BITS-1:0] rs1;
			logic [REG_BITS-1:0] rd;
			logic [OPCODE_BITS-1:0] opcode;
		} f1;
		// For a store the rd slot names the data register
		struct packed {
			logic [MEM_DISP_BITS-1:0] disp;
			logic [REG_BITS-1:0] rs1;
			logic [REG_BITS-1:0] rd;
			logic [OPCODE_BITS-1:0] opcode;
		} m;
		struct packed {
			logic [BR_DISP_BITS-1:0] disp;
			logic [REG_BITS-1:0] rs2;
			logic [REG_BITS-1:0] rs1;
			logic [2:0] cond;
			logic [OPCODE_BITS-1:0] opcode;
		} b;
	} instruction_t;

	// ==================================================================
	// Decoder results and the stage bundle
	// ==================================================================

	typedef struct packed {
		logic isLoad;
		logic isStore;
		memSize_t size;
		logic [DISP_BITS-1:0] disp;
	} memInfo_t;

	typedef struct packed {
		logic isBranch;
		logic isCall;
		logic [2:0] cond;
		logic [DISP_BITS-1:0] disp;
	} branchInfo_t;

	// Register numbers that are not used read zero
	typedef struct packed {
		logic [REG_BITS-1:0] rd;
		logic [REG_BITS-1:0] rs1;
		logic [REG_BITS-1:0] rs2;
		logic writesRd;
		logic readsRs1;
		logic readsRs2;
		logic isFloat;
		logic illegal;
	} regUse_t;

	typedef struct packed {
		logic valid;
		opcode_t opcode;
		unit_t unit;
		memInfo_t mem;
		branchInfo_t branch;
		regUse_t regs;
	} decodeBus_t;

endpackage

`default_nettype wire

/* hw/decode/decodeBranch.sv */
/*
 * Branch decoder.
 * Recognizes conditional branches and calls, passes the condition and
 * gives the word-scaled sign-extended displacement.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeBranch import decodePkg::*;
(
	input instruction_t instr,
	output branchInfo_t branch
);

	// Instructions are word aligned, so the displacement counts words
	logic [DISP_BITS-1:0] dispExt;

	assign dispExt = {{(DISP_BITS-BR_DISP_BITS-2){instr.b.disp[BR_DISP_BITS-1]}},
		instr.b.disp, 2'b00};

	always_comb
	begin
		branch = '0;
		case (instr.b.opcode)
		OP_BCC:
			begin
				branch.isBranch = 1'b1;
				branch.cond = instr.b.cond;
				branch.disp = dispExt;
			end
		// A call is unconditional, its cond stays zero
		OP_JSR:
			begin
				branch.isCall = 1'b1;
				branch.disp = dispExt;
			end
		default:
			branch.isBranch = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/decode/decodeFpu0.sv */
/*
 * FPU0 selector.
 * Flags capability operations and the reciprocal, sine and cosine
 * operations, which only the first floating-point unit can execute.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeFpu0 import decodePkg::*;
(
	input instruction_t instr,
	output logic fpu0
);

	// Nested case on opcode, outer float function and inner float function
	function automatic logic isFpu0(input instruction_t ir);
		case (ir.r3.opcode)
		OP_CAP:
			return 1'b1;
		OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q:
			if (ir.f3.func == FN_FLT1)
			begin
				case (ir.f1.func)
				FN_FRES, FN_FSIN, FN_FCOS:
					return 1'b1;
				default:
					return 1'b0;
				endcase
			end
			else
				return 1'b0;
		default:
			return 1'b0;
		endcase
	endfunction

	assign fpu0 = isFpu0(instr);

endmodule

`default_nettype wire

/* hw/decode/decodeMemory.sv */
/*
 * Memory access decoder.
 * Recognizes loads and stores and gives the access size and the
 * sign-extended displacement.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeMemory import decodePkg::*;
(
	input instruction_t instr,
	output memInfo_t mem
);

	// Sign extension of the m-format displacement to full width
	logic [DISP_BITS-1:0] dispExt;

	assign dispExt = {{(DISP_BITS-MEM_DISP_BITS){instr.m.disp[MEM_DISP_BITS-1]}},
		instr.m.disp};

	always_comb
	begin
		mem = '0;

		// Direction of the access
		case (instr.m.opcode)
		OP_LDB, OP_LDW, OP_LDT, OP_LDO:
			mem.isLoad = 1'b1;
		OP_STB, OP_STW, OP_STT, OP_STO:
			mem.isStore = 1'b1;
		default:
			mem.isLoad = 1'b0;
		endcase

		// Size follows the last letter of the mnemonic
		case (instr.m.opcode)
		OP_LDW, OP_STW:
			mem.size = SIZE_WYDE;
		OP_LDT, OP_STT:
			mem.size = SIZE_TETRA;
		OP_LDO, OP_STO:
			mem.size = SIZE_OCTA;
		default:
			mem.size = SIZE_BYTE;
		endcase

		// The displacement is only meaningful for an access
		if (mem.isLoad || mem.isStore)
			mem.disp = dispExt;
	end

endmodule

`default_nettype wire

/* hw/decode/decodeRegisters.sv */
/*
 * Register use decoder.
 * Extracts the register fields, decides which are read and written,
 * marks float-register use and flags illegal encodings.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeRegisters import decodePkg::*;
(
	input instruction_t instr,
	output regUse_t regs
);

	always_comb
	begin
		regs = '0;
		case (instr.r3.opcode)
		// Two source operands and a destination
		OP_ALU:
			begin
				regs.rd = instr.r3.rd;
				regs.rs1 = instr.r3.rs1;
				regs.rs2 = instr.r3.rs2;
			end
		OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q:
			begin
				regs.isFloat = 1'b1;
				regs.rd = instr.f3.rd;
				regs.rs1 = instr.f3.rs1;
				// Single operand functions carry their code where rs2 would be
				if (instr.f3.func != FN_FLT1)
					regs.rs2 = instr.f3.rs2;
				else if (!(instr.f1.func inside {FN_FRES, FN_FSIN, FN_FCOS, FN_FSQRT,
					FN_FABS, FN_FNEG}))
					regs.illegal = 1'b1;
			end
		OP_ADDI, OP_LDB, OP_LDW, OP_LDT, OP_LDO:
			begin
				regs.rd = instr.m.rd;
				regs.rs1 = instr.m.rs1;
			end
		// Store data comes from the rd slot and is read as rs2
		OP_STB, OP_STW, OP_STT, OP_STO:
			begin
				regs.rs1 = instr.m.rs1;
				regs.rs2 = instr.m.rd;
			end
		OP_BCC:
			begin
				regs.rs1 = instr.b.rs1;
				regs.rs2 = instr.b.rs2;
			end
		OP_JSR:
			regs.rd = LINK_REG;
		// NOP and CAP touch no register
		OP_NOP, OP_CAP:
			regs.illegal = 1'b0;
		default:
			regs.illegal = 1'b1;
		endcase

		// An illegal instruction uses no register at all
		if (regs.illegal)
		begin
			regs.rd = '0;
			regs.rs1 = '0;
			regs.rs2 = '0;
		end

		// Register 0 is never written, unused fields already read zero
		regs.writesRd = (regs.rd != '0);
		regs.readsRs1 = (instr.r3.opcode inside {OP_ALU, OP_ADDI,
			OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q, OP_LDB, OP_LDW, OP_LDT, OP_LDO,
			OP_STB, OP_STW, OP_STT, OP_STO, OP_BCC}) && !regs.illegal;
		regs.readsRs2 = (instr.r3.opcode inside {OP_ALU, OP_STB,
			OP_STW, OP_STT, OP_STO, OP_BCC} || (instr.r3.opcode inside {OP_FLT3H,
			OP_FLT3S, OP_FLT3D, OP_FLT3Q} && instr.f3.func != FN_FLT1)) && !regs.illegal;
	end

endmodule

`default_nettype wire

/* hw/decode/decodeStage.sv */
/*
 * Instruction decode stage.
 * Runs each instruction word through the four decoders, chooses the
 * issue unit and holds the decode bundle in a one-deep stage register.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeStage import decodePkg::*;
(
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic instrValid,
	input instruction_t instr,
	output decodeBus_t decoded
);

	// ==================================================================
	// Decoders
	// ==================================================================

	logic fpu0;
	memInfo_t memInfo;
	branchInfo_t branchInfo;
	regUse_t regUse;

	decodeFpu0 i_decodeFpu0
	(
		.instr(instr),
		.fpu0(fpu0)
	);

	decodeMemory i_decodeMemory
	(
		.instr(instr),
		.mem(memInfo)
	);

	decodeBranch i_decodeBranch
	(
		.instr(instr),
		.branch(branchInfo)
	);

	decodeRegisters i_decodeRegisters
	(
		.instr(instr),
		.regs(regUse)
	);

	// ==================================================================
	// Unit selection and bundle assembly
	// ==================================================================

	decodeBus_t nextBundle;
	unit_t unit;

	// Highest priority first, so an illegal word never reaches a unit
	always_comb
	begin
		if (regUse.illegal)
			unit = UNIT_NONE;
		else if (fpu0)
			unit = UNIT_FPU0;
		else if (memInfo.isLoad || memInfo.isStore)
			unit = UNIT_MEM;
		else if (branchInfo.isBranch || branchInfo.isCall)
			unit = UNIT_BRANCH;
		else if (regUse.isFloat)
			unit = UNIT_FPU;
		else
			unit = UNIT_ALU;
	end

	assign nextBundle.valid = instrValid;
	assign nextBundle.opcode = opcode_t'(instr.r3.opcode);
	assign nextBundle.unit = unit;
	assign nextBundle.mem = memInfo;
	assign nextBundle.branch = branchInfo;
	assign nextBundle.regs = regUse;

	// ==================================================================
	// Stage register
	// ==================================================================

	// Flush wins over stall but only drops valid, the payload may go stale
	always_ff @(posedge clk)
	begin
		if (reset)
			decoded <= '0;
		else if (flush)
			decoded.valid <= 1'b0;
		else if (!stall)
			decoded <= nextBundle;
	end

endmodule

`default_nettype wire

/* tb.f */
common/decodePkg.sv
hw/decode/decodeFpu0.sv
hw/decode/decodeMemory.sv
hw/decode/decodeBranch.sv
hw/decode/decodeRegisters.sv
hw/decode/decodeStage.sv
test/decodeTb.sv

/* test/decodeTb.sv */
/*
 * Testbench for the decode stage.
 * Drives directed and random instruction words with stall and flush,
 * and checks the stage register against a reference decoder.
 */

`timescale 1ns/100ps
`default_nettype none

module decodeTb import decodePkg::*;
();

	logic clk;
	logic reset;
	logic stall;
	logic flush;
	logic instrValid;
	instruction_t instr;
	decodeBus_t decoded;

	// Expected content of the stage register
	decodeBus_t expReg;
	// Stage register content just before the latest rising edge
	decodeBus_t decodedBefore;
	int checkErrors;
	int timeoutErrors;

	opcode_t legalOps[18] = '{OP_NOP, OP_ALU, OP_ADDI, OP_CAP, OP_FLT3H, OP_FLT3S,
		OP_FLT3D, OP_FLT3Q, OP_LDB, OP_LDW, OP_LDT, OP_LDO, OP_STB, OP_STW, OP_STT,
		OP_STO, OP_BCC, OP_JSR};
	opcode_t flt3Ops[4] = '{OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q};
	opcode_t memOps[8] = '{OP_LDB, OP_LDW, OP_LDT, OP_LDO, OP_STB, OP_STW, OP_STT, OP_STO};
	flt1Func_t flt1Funcs[6] = '{FN_FRES, FN_FSIN, FN_FCOS, FN_FSQRT, FN_FABS, FN_FNEG};

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	decodeStage i_decodeStage
	(
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.instrValid(instrValid),
		.instr(instr),
		.decoded(decoded)
	);

	// ==================================================================
	// Reference decoder
	// ==================================================================

	function automatic decodeBus_t refDecode(input instruction_t ir, input logic valid);
		decodeBus_t e;
		logic [6:0] op;
		logic isFlt3;
		logic isFlt1;
		logic isLoad;
		logic isStore;
		logic writes;
		e = '0;
		op = ir.r3.opcode;
		isFlt3 = op inside {OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q};
		isFlt1 = isFlt3 && (ir.f3.func == FN_FLT1);
		isLoad = op inside {OP_LDB, OP_LDW, OP_LDT, OP_LDO};
		isStore = op inside {OP_STB, OP_STW, OP_STT, OP_STO};
		e.valid = valid;
		e.opcode = opcode_t'(op);
		e.regs.isFloat = isFlt3;
		// Unknown opcode, or a single operand function outside the list
		e.regs.illegal = !(op inside {OP_NOP, OP_ALU, OP_ADDI, OP_CAP, OP_BCC, OP_JSR}
			|| isFlt3 || isLoad || isStore) || (isFlt1 && !(ir.f1.func inside
			{FN_FRES, FN_FSIN, FN_FCOS, FN_FSQRT, FN_FABS, FN_FNEG}));
		if (isLoad || isStore)
		begin
			e.mem.isLoad = isLoad;
			e.mem.isStore = isStore;
			// Size from the last letter: B, W, T, O
			case (op)
			OP_LDB, OP_STB: e.mem.size = SIZE_BYTE;
			OP_LDW, OP_STW: e.mem.size = SIZE_WYDE;
			OP_LDT, OP_STT: e.mem.size = SIZE_TETRA;
			default: e.mem.size = SIZE_OCTA;
			endcase
			e.mem.disp = 32'($signed(ir.m.disp));
		end
		e.branch.isBranch = (op == OP_BCC);
		e.branch.isCall = (op == OP_JSR);
		if (op == OP_BCC)
			e.branch.cond = ir.b.cond;
		// Displacement counts words, so it scales by four
		if (op == OP_BCC || op == OP_JSR)
			e.branch.disp = 32'($signed(ir.b.disp)) << 2;
		if (!e.regs.illegal)
		begin
			writes = (op inside {OP_ALU, OP_ADDI, OP_JSR}) || isFlt3 || isLoad;
			e.regs.readsRs1 = (op inside {OP_ALU, OP_ADDI, OP_BCC}) || isFlt3 || isLoad
				|| isStore;
			e.regs.readsRs2 = (op inside {OP_ALU, OP_BCC}) || (isFlt3 && !isFlt1) || isStore;
			if (op == OP_JSR)
				e.regs.rd = LINK_REG;
			else if (writes)
				e.regs.rd = ir.r3.rd;
			e.regs.writesRd = writes && (e.regs.rd != '0);
			if (e.regs.readsRs1)
				e.regs.rs1 = (op == OP_BCC) ? ir.b.rs1 : ir.r3.rs1;
			// Store data sits in the rd slot of the memory format
			if (e.regs.readsRs2)
				e.regs.rs2 = isStore ? ir.m.rd : ((op == OP_BCC) ? ir.b.rs2 : ir.r3.rs2);
		end
		if (e.regs.illegal)
			e.unit = UNIT_NONE;
		else if (op == OP_CAP || (isFlt1 && (ir.f1.func inside {FN_FRES, FN_FSIN, FN_FCOS})))
			e.unit = UNIT_FPU0;
		else if (isLoad || isStore)
			e.unit = UNIT_MEM;
		else if (op == OP_BCC || op == OP_JSR)
			e.unit = UNIT_BRANCH;
		else if (isFlt3)
			e.unit = UNIT_FPU;
		else
			e.unit = UNIT_ALU;
		return e;
	endfunction

	// One-deep model of the stage register, fed from the same edge the DUT sees
	always @(posedge clk)
	begin
		if (reset)
			expReg <= '0;
		else if (flush)
			expReg.valid <= 1'b0;
		else if (!stall)
			expReg <= refDecode(instr, instrValid);
	end

	// Snapshot taken before the register updates, for the stall check
	always @(posedge clk)
		decodedBefore <= decoded;

	// ==================================================================
	// Checks
	// ==================================================================

	task automatic reportMismatch(input string field, input logic [127:0] expVal,
		input logic [127:0] actVal);
		checkErrors++;
		$display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, field, expVal, actVal);
	endtask

	// Outputs settle after the rising edge, so everything is sampled on the falling edge
	validOk: assert property (@(negedge clk) disable iff (reset) decoded.valid == expReg.valid)
		else reportMismatch("decoded.valid", expReg.valid, decoded.valid);
	opcodeOk: assert property (@(negedge clk) disable iff (reset)
		expReg.valid |-> decoded.opcode == expReg.opcode)
		else reportMismatch("decoded.opcode", expReg.opcode, decoded.opcode);
	unitOk: assert property (@(negedge clk) disable iff (reset)
		expReg.valid |-> decoded.unit == expReg.unit)
		else reportMismatch("decoded.unit", expReg.unit, decoded.unit);
	memOk: assert property (@(negedge clk) disable iff (reset)
		expReg.valid |-> decoded.mem == expReg.mem)
		else reportMismatch("decoded.mem", expReg.mem, decoded.mem);
	branchOk: assert property (@(negedge clk) disable iff (reset)
		expReg.valid |-> decoded.branch == expReg.branch)
		else reportMismatch("decoded.branch", expReg.branch, decoded.branch);
	regsOk: assert property (@(negedge clk) disable iff (reset)
		expReg.valid |-> decoded.regs == expReg.regs)
		else reportMismatch("decoded.regs", expReg.regs, decoded.regs);
	// Stage behavior independent of the reference decoder
	stallHolds: assert property (@(negedge clk) disable iff (reset)
		(stall && !flush) |=> decoded == decodedBefore)
		else reportMismatch("decoded under stall", decodedBefore, decoded);
	flushClears: assert property (@(negedge clk) disable iff (reset) flush |=> !decoded.valid)
		else reportMismatch("decoded.valid after flush", 1'b0, decoded.valid);
	resetClears: assert property (@(negedge clk) reset |=> decoded == '0)
		else reportMismatch("decoded after reset", 128'h0, decoded);

	// ==================================================================
	// Stimulus
	// ==================================================================

	function automatic instruction_t r3Word(input logic [6:0] op, input logic [5:0] rd,
		input logic [5:0] rs1, input logic [5:0] rs2, input logic [6:0] func);
		instruction_t ir;
		ir.r3 = '{func: func, rs2: rs2, rs1: rs1, rd: rd, opcode: op};
		return ir;
	endfunction

	function automatic instruction_t memWord(input logic [6:0] op, input logic [5:0] rd,
		input logic [5:0] rs1, input logic [12:0] disp);
		instruction_t ir;
		ir.m = '{disp: disp, rs1: rs1, rd: rd, opcode: op};
		return ir;
	endfunction

	function automatic instruction_t branchWord(input logic [6:0] op, input logic [2:0] cond,
		input logic [5:0] rs1, input logic [5:0] rs2, input logic [9:0] disp);
		instruction_t ir;
		ir.b = '{disp: disp, rs2: rs2, rs1: rs1, cond: cond, opcode: op};
		return ir;
	endfunction

	// Mostly legal opcodes, and half the float words take the single operand form
	function automatic instruction_t randomInstr();
		instruction_t ir;
		ir.raw = $urandom;
		if ($urandom_range(9) != 0)
			ir.r3.opcode = legalOps[$urandom_range(17)];
		if ((ir.r3.opcode inside {OP_FLT3H, OP_FLT3S, OP_FLT3D, OP_FLT3Q})
			&& $urandom_range(1) == 1)
		begin
			ir.f3.func = FN_FLT1;
			if ($urandom_range(4) != 0)
				ir.f1.func = flt1Funcs[$urandom_range(5)];
		end
		return ir;
	endfunction

	task automatic waitValidLevel(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (decoded.valid !== level && cycles < 4)
		begin
			@(negedge clk);
			cycles++;
		end
		if (decoded.valid !== level)
		begin
			timeoutErrors++;
			$display("Timeout at %0t: decoded.valid never reached %0b", $time, level);
		end
	endtask

	// Offer one word for a single edge and wait until it shows up decoded
	task automatic sendInstr(input instruction_t ir);
		@(posedge clk);
		instr <= ir;
		instrValid <= 1'b1;
		@(posedge clk);
		instrValid <= 1'b0;
		waitValidLevel(1'b1);
	endtask

	task automatic runDirected();
		sendInstr(r3Word(OP_CAP, 6'd5, 6'd6, 6'd7, 7'h00));
		foreach (flt3Ops[p])
		begin
			// The single operand function code travels in the rs2 slot
			foreach (flt1Funcs[f])
				sendInstr(r3Word(flt3Ops[p], 6'd3, 6'd4, flt1Funcs[f], {FN_FLT1, 3'd1}));
			sendInstr(r3Word(flt3Ops[p], 6'd3, 6'd4, 6'd5, {FN_FADD, 3'd2}));
			sendInstr(r3Word(flt3Ops[p], 6'd6, 6'd7, 6'd8, {FN_FMUL, 3'd0}));
			sendInstr(r3Word(flt3Ops[p], 6'd9, 6'd10, 6'd11, {FN_FDIV, 3'd3}));
		end
		foreach (memOps[m])
		begin
			sendInstr(memWord(memOps[m], 6'd12, 6'd13, 13'h0123));
			sendInstr(memWord(memOps[m], 6'd14, 6'd15, 13'h1F80));
		end
		sendInstr(branchWord(OP_BCC, 3'd5, 6'd2, 6'd3, 10'h011));
		sendInstr(branchWord(OP_BCC, 3'd7, 6'd4, 6'd0, 10'h3F0));
		sendInstr(branchWord(OP_JSR, 3'd6, 6'd8, 6'd9, 10'h200));
		// Writes to register 0 and words that must decode as illegal
		sendInstr(r3Word(OP_ALU, 6'd0, 6'd1, 6'd2, 7'h11));
		sendInstr(memWord(OP_ADDI, 6'd0, 6'd3, 13'h0005));
		sendInstr(memWord(OP_LDB, 6'd0, 6'd0, 13'h0000));
		sendInstr(r3Word(OP_NOP, 6'd4, 6'd5, 6'd6, 7'h00));
		sendInstr(r3Word(7'h7F, 6'd4, 6'd5, 6'd6, 7'h00));
		sendInstr(r3Word(7'h11, 6'd7, 6'd8, 6'd9, 7'h22));
		sendInstr(r3Word(OP_FLT3D, 6'd7, 6'd8, 6'h3F, {FN_FLT1, 3'd0}));
	endtask

	// Capture one load, hold it under stall, then flush while still stalled
	task automatic holdAndFlush();
		@(posedge clk);
		instr <= memWord(OP_LDT, 6'd9, 6'd10, 13'h1FFC);
		instrValid <= 1'b1;
		@(posedge clk);
		stall <= 1'b1;
		waitValidLevel(1'b1);
		repeat (3) @(posedge clk);
		flush <= 1'b1;
		waitValidLevel(1'b0);
		@(posedge clk);
		flush <= 1'b0;
		stall <= 1'b0;
		instrValid <= 1'b0;
	endtask

	task automatic runRandom();
		repeat (400)
		begin
			@(posedge clk);
			// Upstream keeps its word steady while the stage is stalled
			if (!stall)
				instr <= randomInstr();
			instrValid <= ($urandom_range(3) != 0);
			stall <= ($urandom_range(4) == 0);
			flush <= ($urandom_range(9) == 0);
		end
	endtask

	initial
	begin
		void'($urandom(78267));
		checkErrors = 0;
		timeoutErrors = 0;
		reset = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		runDirected();
		holdAndFlush();
		runRandom();
		@(posedge clk);
		instrValid <= 1'b0;
		stall <= 1'b0;
		flush <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		$display("Errors: %0d check, %0d timeout", checkErrors, timeoutErrors);
		if (checkErrors == 0 && timeoutErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
